/* hdl/dataframe_pkg.sv */
`default_nettype none

package dataframe_pkg;

    localparam int NUM_CH = 2;
    localparam int CH_SEL_WIDTH = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

    localparam int SAMPLE_WIDTH = 16;
    localparam int SAMPLE_NUM_PER_CLK = 8;
    localparam int RFDC_TDATA_WIDTH = SAMPLE_WIDTH * SAMPLE_NUM_PER_CLK;
    localparam int DATAFRAME_WIDTH = 64;
    localparam int RECORD_WIDTH = 3 * DATAFRAME_WIDTH;

    localparam int TRIGGER_TYPE_WIDTH = 3;
    localparam int TRIGGER_INFO_WIDTH = 1 + TRIGGER_TYPE_WIDTH;
    localparam int HEADER_TIMESTAMP_WIDTH = 32;
    localparam int FOOTER_TIMESTAMP_WIDTH = 16;
    localparam int TIMESTAMP_WIDTH = HEADER_TIMESTAMP_WIDTH + FOOTER_TIMESTAMP_WIDTH;
    localparam int TRIGGER_CONFIG_WIDTH = 8;
    localparam int TRIGGER_WORD_WIDTH = RFDC_TDATA_WIDTH + TRIGGER_INFO_WIDTH
                                      + TIMESTAMP_WIDTH + TRIGGER_CONFIG_WIDTH;

    // field offsets inside one trigger word
    localparam int HTS_LSB = TRIGGER_CONFIG_WIDTH;
    localparam int FTS_LSB = HTS_LSB + HEADER_TIMESTAMP_WIDTH;
    localparam int TYPE_LSB = FTS_LSB + FOOTER_TIMESTAMP_WIDTH;
    localparam int GAIN_BIT = TYPE_LSB + TRIGGER_TYPE_WIDTH;
    localparam int ADC_LSB = GAIN_BIT + 1;

    localparam int FRAME_LENGTH_WIDTH = 16;
    localparam int OBJECT_ID_WIDTH = 16;
    localparam int CHARGE_SUM_WIDTH = 24;
    localparam int LANE_SUM_WIDTH = CHARGE_SUM_WIDTH - 3;
    localparam int CH_ID_WIDTH = 4;
    localparam int TS_HI_WIDTH = 21;
    localparam int TS_LO_WIDTH = HEADER_TIMESTAMP_WIDTH - TS_HI_WIDTH;

    localparam logic [15:0] HEADER_ID = 16'h5A5A;
    localparam logic [15:0] FOOTER_ID = 16'hA5A5;

    localparam logic [1:0] STATE_IDLE = 2'b00;
    localparam logic [1:0] STATE_FIRST = 2'b01;
    localparam logic [1:0] STATE_CONT = 2'b11;
    localparam logic [1:0] STATE_HALT = 2'b10;

    localparam logic [FRAME_LENGTH_WIDTH-1:0] DEFAULT_MAX_TRIGGER_LEN = 16'd100;

    localparam int ADC_FIFO_DEPTH = 16;
    localparam int HF_FIFO_DEPTH = 4;

    // merger frame FSM
    localparam logic [2:0] MRG_IDLE = 3'd0;
    localparam logic [2:0] MRG_HDR0 = 3'd1;
    localparam logic [2:0] MRG_HDR1 = 3'd2;
    localparam logic [2:0] MRG_DLO = 3'd3;
    localparam logic [2:0] MRG_DHI = 3'd4;
    localparam logic [2:0] MRG_FTR = 3'd5;

    typedef struct packed {
        logic [15:0] header_id;
        logic [CH_ID_WIDTH-1:0] ch_id;
        logic [FRAME_LENGTH_WIDTH-1:0] frame_len;
        logic [3:0] frame_info;
        logic [TRIGGER_TYPE_WIDTH-1:0] trigger_type;
        logic [TS_HI_WIDTH-1:0] ts_hi;
    } header0_t;

    typedef struct packed {
        logic [15:0] pad;
        logic [FOOTER_TIMESTAMP_WIDTH-1:0] footer_ts;
        logic [OBJECT_ID_WIDTH-1:0] object_id;
        logic [15:0] footer_id;
    } footer_t;

    typedef union packed {
        header0_t header;
        footer_t footer;
    } dataframe_word_u;

endpackage

`default_nettype wire

/* hdl/fifo_port_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface fifo_port_if #(
    parameter int WIDTH = 64
);
    logic [WIDTH-1:0] wdata;
    logic wen;
    logic [WIDTH-1:0] rdata;
    logic ren;
    logic empty;
    logic almost_full;
    logic full;

    // writer also sees ren to tell when a write fills the buffer
    modport writer (output wdata, output wen, input almost_full, input full, input ren);
    modport buffer (
        input wdata, input wen, input ren,
        output rdata, output empty, output almost_full, output full
    );
    modport reader (output ren, input rdata, input empty);

endinterface

`default_nettype wire

/* hdl/sync_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter int DEPTH = 16
) (
    input logic ACLK,
    input logic ARESET,
    fifo_port_if.buffer port
);
    logic [$bits(port.wdata)-1:0] mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wptr;
    logic [$clog2(DEPTH)-1:0] rptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic do_write;
    logic do_read;

    assign do_write = port.wen & ~port.full;
    assign do_read = port.ren & ~port.empty;

    assign port.rdata = mem[rptr];
    assign port.empty = (count == 0);
    assign port.full = (count == DEPTH);
    assign port.almost_full = (count >= DEPTH - 1);

    always_ff @(posedge ACLK) begin
        if (do_write) begin
            mem[wptr] <= port.wdata;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wptr <= '0;
            rptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wptr <= (wptr == $clog2(DEPTH)'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (do_read) begin
                rptr <= (rptr == $clog2(DEPTH)'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    no_overflow: assert property (@(posedge ACLK) disable iff (ARESET)
        port.wen |-> !port.full);

endmodule

`default_nettype wire

/* hdl/header_footer_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module header_footer_gen #(
    parameter int CHANNEL_ID = 0
) (
    input logic ACLK,
    input logic ARESET,
    input logic set_config,
    input logic [dataframe_pkg::FRAME_LENGTH_WIDTH-1:0] max_trigger_length,
    input logic [dataframe_pkg::TRIGGER_WORD_WIDTH-1:0] trigger_tdata,
    input logic trigger_tvalid,
    fifo_port_if.writer adc,
    fifo_port_if.writer record
);
    import dataframe_pkg::*;

    logic tvalid_d;
    logic rise;
    logic fall;
    logic halt_in;
    logic start;
    logic wen_q;
    logic [RFDC_TDATA_WIDTH-1:0] adc_data;
    logic [FRAME_LENGTH_WIDTH-2:0] frame_len;
    logic [FRAME_LENGTH_WIDTH-1:0] beats;
    logic [FRAME_LENGTH_WIDTH-1:0] max_len;
    logic split;
    logic adc_gets_full;
    logic hf_gets_full;
    logic halting;
    logic frame_continue;
    logic [1:0] run_state;
    logic [1:0] frame_state;
    logic gain;
    logic [TRIGGER_TYPE_WIDTH-1:0] trig_type;
    logic [HEADER_TIMESTAMP_WIDTH-1:0] header_ts;
    logic [FOOTER_TIMESTAMP_WIDTH-1:0] footer_ts;
    logic [TRIGGER_CONFIG_WIDTH-1:0] trig_cfg;
    logic [OBJECT_ID_WIDTH-1:0] object_id;
    logic [LANE_SUM_WIDTH-1:0] lane_sum [SAMPLE_NUM_PER_CLK];
    logic [LANE_SUM_WIDTH-1:0] lane_next [SAMPLE_NUM_PER_CLK];
    logic [CHARGE_SUM_WIDTH-1:0] low_sum;
    logic [CHARGE_SUM_WIDTH-1:0] high_sum;
    logic [CHARGE_SUM_WIDTH-1:0] charge;
    dataframe_word_u hdr0;
    dataframe_word_u ftr;
    logic [DATAFRAME_WIDTH-1:0] hdr1;

    assign rise = trigger_tvalid & ~tvalid_d;
    assign fall = ~trigger_tvalid & tvalid_d;
    assign halt_in = set_config | adc.full | record.full;
    assign start = rise & ~halt_in;

    assign adc.wen = wen_q & ~halt_in;
    assign adc.wdata = adc_data;

    // beats of the frame including the one written now
    assign beats = {1'b0, frame_len} + 1'b1;
    assign split = adc.wen & (beats == max_len);
    assign adc_gets_full = adc.almost_full & adc.wen & ~adc.ren;
    assign record.wen = adc.wen & (fall | split | adc_gets_full);
    assign hf_gets_full = record.almost_full & record.wen & ~record.ren;
    assign halting = adc_gets_full | hf_gets_full;
    assign frame_continue = split & trigger_tvalid & ~halting;
    assign frame_state = halting ? STATE_HALT : run_state;

    always_comb begin
        logic [LANE_SUM_WIDTH:0] sum;
        high_sum = '0;
        for (int j = 0; j < SAMPLE_NUM_PER_CLK; j++) begin
            sum = {1'b0, lane_sum[j]} + trigger_tdata[ADC_LSB + SAMPLE_WIDTH*j +: SAMPLE_WIDTH];
            // saturate each lane on its own
            lane_next[j] = sum[LANE_SUM_WIDTH] ? '1 : sum[LANE_SUM_WIDTH-1:0];
            high_sum = high_sum + lane_sum[j];
        end
    end

    assign charge = gain ? high_sum : low_sum;

    always_comb begin
        hdr0.header.header_id = HEADER_ID;
        hdr0.header.ch_id = CH_ID_WIDTH'(CHANNEL_ID);
        hdr0.header.frame_len = {beats[FRAME_LENGTH_WIDTH-2:0], 1'b0};
        hdr0.header.frame_info = {1'b0, frame_state, frame_continue};
        hdr0.header.trigger_type = trig_type;
        hdr0.header.ts_hi = header_ts[HEADER_TIMESTAMP_WIDTH-1 -: TS_HI_WIDTH];
        ftr.footer.pad = '0;
        ftr.footer.footer_ts = footer_ts;
        ftr.footer.object_id = object_id;
        ftr.footer.footer_id = FOOTER_ID;
    end

    assign hdr1 = {header_ts[TS_LO_WIDTH-1:0], {TS_HI_WIDTH{1'b0}}, charge, trig_cfg};
    assign record.wdata = {hdr0, hdr1, ftr};

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            tvalid_d <= 1'b0;
            max_len <= DEFAULT_MAX_TRIGGER_LEN;
            object_id <= '1;
        end else begin
            tvalid_d <= trigger_tvalid;
            if (set_config) begin
                max_len <= max_trigger_length;
                object_id <= '1;
            end else if (start) begin
                object_id <= object_id + 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET || halt_in) begin
            run_state <= STATE_IDLE;
            wen_q <= 1'b0;
        end else if (start) begin
            run_state <= STATE_FIRST;
            wen_q <= 1'b1;
        end else if (halting) begin
            // stays off until the window opens again
            run_state <= STATE_HALT;
            wen_q <= 1'b0;
        end else if (frame_continue) begin
            run_state <= STATE_CONT;
        end else if (record.wen) begin
            run_state <= STATE_IDLE;
            wen_q <= 1'b0;
        end
    end

    always_ff @(posedge ACLK) begin
        adc_data <= trigger_tdata[ADC_LSB +: RFDC_TDATA_WIDTH];
        if (start || frame_continue) begin
            gain <= trigger_tdata[GAIN_BIT];
            trig_type <= trigger_tdata[TYPE_LSB +: TRIGGER_TYPE_WIDTH];
            footer_ts <= trigger_tdata[FTS_LSB +: FOOTER_TIMESTAMP_WIDTH];
            header_ts <= trigger_tdata[HTS_LSB +: HEADER_TIMESTAMP_WIDTH];
            trig_cfg <= trigger_tdata[TRIGGER_CONFIG_WIDTH-1:0];
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET || halt_in || !trigger_tvalid) begin
            frame_len <= '1;
            low_sum <= '0;
            for (int j = 0; j < SAMPLE_NUM_PER_CLK; j++) begin
                lane_sum[j] <= '0;
            end
        end else if (start || frame_continue) begin
            frame_len <= '0;
            low_sum <= CHARGE_SUM_WIDTH'(trigger_tdata[ADC_LSB +: SAMPLE_WIDTH]);
            for (int j = 0; j < SAMPLE_NUM_PER_CLK; j++) begin
                lane_sum[j] <= LANE_SUM_WIDTH'(
                    trigger_tdata[ADC_LSB + SAMPLE_WIDTH*j +: SAMPLE_WIDTH]);
            end
        end else if (adc.wen) begin
            frame_len <= frame_len + 1'b1;
            low_sum <= low_sum + trigger_tdata[ADC_LSB +: SAMPLE_WIDTH];
            lane_sum <= lane_next;
        end
    end

    // the almost-full look-ahead ends a running frame before either FIFO fills
    record_no_overflow: assert property (@(posedge ACLK) disable iff (ARESET)
        wen_q |-> !record.full);
    adc_no_overflow: assert property (@(posedge ACLK) disable iff (ARESET)
        wen_q |-> !adc.full);

endmodule

`default_nettype wire

/* hdl/frame_merger.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_merger (
    input logic ACLK,
    input logic ARESET,
    fifo_port_if.reader adc [dataframe_pkg::NUM_CH],
    fifo_port_if.reader record [dataframe_pkg::NUM_CH],
    output logic [dataframe_pkg::DATAFRAME_WIDTH-1:0] out_data,
    output logic out_valid,
    output logic out_last
);
    import dataframe_pkg::*;

    logic [NUM_CH-1:0] adc_empty;
    logic [NUM_CH-1:0] rec_empty;
    logic [NUM_CH-1:0] adc_ren;
    logic [NUM_CH-1:0] rec_ren;
    logic [RFDC_TDATA_WIDTH-1:0] adc_rdata [NUM_CH];
    logic [RECORD_WIDTH-1:0] rec_rdata [NUM_CH];
    logic [2:0] state;
    logic [CH_SEL_WIDTH-1:0] grant;
    logic [CH_SEL_WIDTH-1:0] prio;
    logic [CH_SEL_WIDTH-1:0] pick;
    logic pick_valid;
    logic [FRAME_LENGTH_WIDTH-1:0] beats_left;
    logic [RFDC_TDATA_WIDTH-1:0] cur_adc;
    logic [RECORD_WIDTH-1:0] cur_rec;
    dataframe_word_u hdr_view;

    for (genvar g = 0; g < NUM_CH; g++) begin : g_port
        assign adc_empty[g] = adc[g].empty;
        assign rec_empty[g] = record[g].empty;
        assign adc_rdata[g] = adc[g].rdata;
        assign rec_rdata[g] = record[g].rdata;
        assign adc[g].ren = adc_ren[g];
        assign record[g].ren = rec_ren[g];
    end

    assign cur_adc = adc_rdata[grant];
    assign cur_rec = rec_rdata[grant];
    assign hdr_view = cur_rec[RECORD_WIDTH-1 -: DATAFRAME_WIDTH];

    // round robin, starting from prio
    always_comb begin
        int idx;
        pick = prio;
        pick_valid = 1'b0;
        for (int k = NUM_CH - 1; k >= 0; k--) begin
            idx = (prio + k) % NUM_CH;
            if (!rec_empty[idx]) begin
                pick = CH_SEL_WIDTH'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    always_comb begin
        adc_ren = '0;
        rec_ren = '0;
        if (state == MRG_DHI) begin
            adc_ren[grant] = 1'b1;
        end
        if (state == MRG_FTR) begin
            rec_ren[grant] = 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            state <= MRG_IDLE;
            grant <= '0;
            prio <= '0;
            beats_left <= '0;
            out_valid <= 1'b0;
            out_last <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            out_last <= 1'b0;
            case (state)
                MRG_IDLE: begin
                    if (pick_valid) begin
                        grant <= pick;
                        state <= MRG_HDR0;
                    end
                end
                MRG_HDR0: begin
                    out_data <= hdr_view;
                    out_valid <= 1'b1;
                    beats_left <= hdr_view.header.frame_len >> 1;
                    state <= MRG_HDR1;
                end
                MRG_HDR1: begin
                    out_data <= cur_rec[2*DATAFRAME_WIDTH-1 -: DATAFRAME_WIDTH];
                    out_valid <= 1'b1;
                    state <= MRG_DLO;
                end
                MRG_DLO: begin
                    if (!adc_empty[grant]) begin
                        out_data <= cur_adc[DATAFRAME_WIDTH-1:0];
                        out_valid <= 1'b1;
                        state <= MRG_DHI;
                    end
                end
                MRG_DHI: begin
                    out_data <= cur_adc[RFDC_TDATA_WIDTH-1 -: DATAFRAME_WIDTH];
                    out_valid <= 1'b1;
                    beats_left <= beats_left - 1'b1;
                    state <= (beats_left == 1) ? MRG_FTR : MRG_DLO;
                end
                MRG_FTR: begin
                    out_data <= cur_rec[DATAFRAME_WIDTH-1:0];
                    out_valid <= 1'b1;
                    out_last <= 1'b1;
                    prio <= (grant == CH_SEL_WIDTH'(NUM_CH - 1)) ? '0 : grant + 1'b1;
                    state <= MRG_IDLE;
                end
                default: state <= MRG_IDLE;
            endcase
        end
    end

    // the last word is a valid footer of the granted record
    last_with_valid: assert property (@(posedge ACLK) disable iff (ARESET)
        out_last |-> out_valid && (out_data[15:0] == FOOTER_ID));

endmodule

`default_nettype wire

/* hdl/daq_readout_top.sv */
`timescale 1ns/1ns
`default_nettype none

module daq_readout_top (
    input logic ACLK,
    input logic ARESET,
    input logic set_config,
    input logic [dataframe_pkg::FRAME_LENGTH_WIDTH-1:0] max_trigger_length,
    input logic [dataframe_pkg::NUM_CH-1:0][dataframe_pkg::TRIGGER_WORD_WIDTH-1:0] trigger_tdata,
    input logic [dataframe_pkg::NUM_CH-1:0] trigger_tvalid,
    output logic [dataframe_pkg::DATAFRAME_WIDTH-1:0] out_data,
    output logic out_valid,
    output logic out_last
);
    import dataframe_pkg::*;

    fifo_port_if #(.WIDTH(RFDC_TDATA_WIDTH)) adc_fifo [NUM_CH] ();
    fifo_port_if #(.WIDTH(RECORD_WIDTH)) rec_fifo [NUM_CH] ();

    for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
        header_footer_gen #(.CHANNEL_ID(g)) u_hf_gen (
            .ACLK(ACLK),
            .ARESET(ARESET),
            .set_config(set_config),
            .max_trigger_length(max_trigger_length),
            .trigger_tdata(trigger_tdata[g]),
            .trigger_tvalid(trigger_tvalid[g]),
            .adc(adc_fifo[g]),
            .record(rec_fifo[g])
        );

        sync_fifo #(.DEPTH(ADC_FIFO_DEPTH)) u_adc_fifo (
            .ACLK(ACLK),
            .ARESET(ARESET),
            .port(adc_fifo[g])
        );
        sync_fifo #(.DEPTH(HF_FIFO_DEPTH)) u_rec_fifo (
            .ACLK(ACLK),
            .ARESET(ARESET),
            .port(rec_fifo[g])
        );
    end

    frame_merger u_merger (
        .ACLK(ACLK),
        .ARESET(ARESET),
        .adc(adc_fifo),
        .record(rec_fifo),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_last(out_last)
    );

endmodule

`default_nettype wire

/* tb/tb_daq_readout.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_daq_readout;
    import dataframe_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS = 5;
    localparam int MAX_BEATS = 64;
    localparam longint LANE_MAX = (64'd1 << LANE_SUM_WIDTH) - 1;

    logic ACLK = 1'b0;
    logic ARESET;
    logic set_config;
    logic [FRAME_LENGTH_WIDTH-1:0] max_trigger_length;
    logic [NUM_CH-1:0][TRIGGER_WORD_WIDTH-1:0] trigger_tdata;
    logic [NUM_CH-1:0] trigger_tvalid;
    logic [DATAFRAME_WIDTH-1:0] out_data;
    logic out_valid;
    logic out_last;

    integer seed = 32'h3833f1ed;
    int errors = 0;
    int checks = 0;
    int frames_seen = 0;
    int test_errors = 0;
    int max_len = DEFAULT_MAX_TRIGGER_LEN;
    int last_ch = -1;
    logic check_alt = 1'b0;
    logic [OBJECT_ID_WIDTH-1:0] obj_id [NUM_CH];
    logic [TRIGGER_WORD_WIDTH-1:0] beat_mem [NUM_CH][MAX_BEATS];
    dataframe_word_u exp_words [NUM_CH][$];
    logic [1:0] exp_state [NUM_CH][$];
    int exp_count [NUM_CH][$];
    dataframe_word_u got [$];

    daq_readout_top DUT (
        .ACLK(ACLK),
        .ARESET(ARESET),
        .set_config(set_config),
        .max_trigger_length(max_trigger_length),
        .trigger_tdata(trigger_tdata),
        .trigger_tvalid(trigger_tvalid),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_last(out_last)
    );

    always #(CLK_PERIOD / 2) ACLK = ~ACLK;

    task automatic check_word(input dataframe_word_u got_w, input dataframe_word_u exp_w,
                              input string name);
        checks++;
        if (got_w !== exp_w) begin
            errors++;
            $display("Fail %0t %s: got %h expected %h", $time, name, got_w, exp_w);
        end
    endtask

    task automatic check_state(input logic [1:0] got_s, input logic [1:0] exp_s);
        checks++;
        if (got_s !== exp_s) begin
            errors++;
            $display("Fail %0t frame_state: got %b expected %b", $time, got_s, exp_s);
        end
    endtask

    // expected words of one frame made of n beats starting at first
    function automatic void build_frame(input int ch, input int first, input int n,
                                        input logic [1:0] state, input logic cont);
        logic [TRIGGER_WORD_WIDTH-1:0] b0;
        logic [RFDC_TDATA_WIDTH-1:0] adc;
        logic [HEADER_TIMESTAMP_WIDTH-1:0] hts;
        logic [CHARGE_SUM_WIDTH-1:0] charge;
        longint lane [SAMPLE_NUM_PER_CLK];
        longint high;
        longint low;
        dataframe_word_u w;
        b0 = beat_mem[ch][first];
        hts = b0[HTS_LSB +: HEADER_TIMESTAMP_WIDTH];
        low = 0;
        high = 0;
        foreach (lane[j]) lane[j] = 0;
        for (int i = first; i < first + n; i++) begin
            adc = beat_mem[ch][i][ADC_LSB +: RFDC_TDATA_WIDTH];
            low += adc[SAMPLE_WIDTH-1:0];
            for (int j = 0; j < SAMPLE_NUM_PER_CLK; j++) begin
                lane[j] += adc[SAMPLE_WIDTH*j +: SAMPLE_WIDTH];
                // each lane clips at its own maximum
                if (lane[j] > LANE_MAX) lane[j] = LANE_MAX;
            end
        end
        foreach (lane[j]) high += lane[j];
        charge = b0[GAIN_BIT] ? high[CHARGE_SUM_WIDTH-1:0] : low[CHARGE_SUM_WIDTH-1:0];
        w.header.header_id = HEADER_ID;
        w.header.ch_id = CH_ID_WIDTH'(ch);
        w.header.frame_len = FRAME_LENGTH_WIDTH'(2 * n);
        w.header.frame_info = {1'b0, state, cont};
        w.header.trigger_type = b0[TYPE_LSB +: TRIGGER_TYPE_WIDTH];
        w.header.ts_hi = hts[HEADER_TIMESTAMP_WIDTH-1 -: TS_HI_WIDTH];
        exp_words[ch].push_back(w);
        w = {hts[TS_LO_WIDTH-1:0], {TS_HI_WIDTH{1'b0}}, charge, b0[TRIGGER_CONFIG_WIDTH-1:0]};
        exp_words[ch].push_back(w);
        for (int i = first; i < first + n; i++) begin
            adc = beat_mem[ch][i][ADC_LSB +: RFDC_TDATA_WIDTH];
            exp_words[ch].push_back(adc[DATAFRAME_WIDTH-1:0]);
            exp_words[ch].push_back(adc[RFDC_TDATA_WIDTH-1 -: DATAFRAME_WIDTH]);
        end
        w.footer.pad = '0;
        w.footer.footer_ts = b0[FTS_LSB +: FOOTER_TIMESTAMP_WIDTH];
        w.footer.object_id = obj_id[ch];
        w.footer.footer_id = FOOTER_ID;
        exp_words[ch].push_back(w);
        exp_state[ch].push_back(state);
        exp_count[ch].push_back(2 * n + 3);
    endfunction

    task automatic check_frame();
        dataframe_word_u hdr;
        dataframe_word_u exp_w;
        int ch;
        int n;
        hdr = got[0];
        ch = hdr.header.ch_id;
        frames_seen++;
        if (got.size() != hdr.header.frame_len + 3) begin
            errors++;
            $display("frame at %0t holds %0d words but its header announces %0d data words",
                     $time, got.size(), hdr.header.frame_len);
        end
        if (ch >= NUM_CH || exp_count[ch].size() == 0) begin
            errors++;
            $display("unexpected frame with channel field %0d at %0t", ch, $time);
            return;
        end
        if (check_alt && ch == last_ch) begin
            errors++;
            $display("two frames in a row from channel %0d at %0t", ch, $time);
        end
        last_ch = ch;
        n = exp_count[ch].pop_front();
        check_state(hdr.header.frame_info[2:1], exp_state[ch].pop_front());
        if (got.size() != n) begin
            errors++;
            $display("frame of channel %0d has %0d words, expected %0d", ch, got.size(), n);
        end
        for (int i = 0; i < n; i++) begin
            exp_w = exp_words[ch].pop_front();
            if (i < got.size()) check_word(got[i], exp_w, $sformatf("out_data[%0d]", i));
        end
    endtask

    always @(negedge ACLK) begin
        if (!ARESET && out_valid) begin
            got.push_back(dataframe_word_u'(out_data));
            if (out_last) begin
                check_frame();
                got.delete();
            end
        end
    end

    task automatic configure(input int len);
        @(posedge ACLK);
        #2;
        set_config = 1'b1;
        max_trigger_length = FRAME_LENGTH_WIDTH'(len);
        @(posedge ACLK);
        #2;
        set_config = 1'b0;
        max_len = len;
        foreach (obj_id[c]) obj_id[c] = '1;
    endtask

    task automatic run_window(input logic [NUM_CH-1:0] mask, input int n, input logic gain);
        int pos;
        int len;
        logic halt;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (mask[ch]) begin
                obj_id[ch] = obj_id[ch] + 1'b1;
                for (int i = 0; i < n; i++) begin
                    beat_mem[ch][i] = TRIGGER_WORD_WIDTH'({$random(seed), $random(seed),
                        $random(seed), $random(seed), $random(seed), $random(seed)});
                    beat_mem[ch][i][GAIN_BIT] = gain;
                end
                pos = 0;
                while (pos < n) begin
                    len = (n - pos > max_len) ? max_len : n - pos;
                    // ADC FIFO fills up before the merger sees any record
                    halt = (len >= ADC_FIFO_DEPTH);
                    if (halt) len = ADC_FIFO_DEPTH;
                    build_frame(ch, pos, len,
                                halt ? STATE_HALT : (pos == 0) ? STATE_FIRST : STATE_CONT,
                                !halt && (pos + len < n));
                    pos = halt ? n : pos + len;
                end
            end
        end
        for (int i = 0; i < n; i++) begin
            @(posedge ACLK);
            #2;
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (mask[ch]) begin
                    trigger_tdata[ch] = beat_mem[ch][i];
                    trigger_tvalid[ch] = 1'b1;
                end
            end
        end
        @(posedge ACLK);
        #2;
        trigger_tvalid = '0;
    endtask

    task automatic wait_drain();
        while (exp_count[0].size() + exp_count[1].size() != 0) @(negedge ACLK);
        repeat (4) @(posedge ACLK);
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == test_errors) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        ARESET = 1'b1;
        set_config = 1'b0;
        max_trigger_length = '0;
        trigger_tdata = '0;
        trigger_tvalid = '0;
        foreach (obj_id[c]) obj_id[c] = '1;
        repeat (5) @(posedge ACLK);
        #2;
        ARESET = 1'b0;
        repeat (2) @(posedge ACLK);

        run_window(2'b01, 5, 1'b0);
        wait_drain();
        report_test(1, "low-gain window on channel 0");

        run_window(2'b10, 7, 1'b1);
        wait_drain();
        report_test(2, "high-gain charge sum");

        configure(4);
        run_window(2'b01, 10, 1'b0);
        wait_drain();
        report_test(3, "split at maximum length 4");

        check_alt = 1'b1;
        run_window(2'b11, 6, 1'b1);
        wait_drain();
        run_window(2'b11, 6, 1'b0);
        wait_drain();
        check_alt = 1'b0;
        report_test(4, "both channels at once");

        configure(DEFAULT_MAX_TRIGGER_LEN);
        run_window(2'b01, 30, 1'b1);
        wait_drain();
        run_window(2'b01, 5, 1'b0);
        wait_drain();
        report_test(5, "ADC FIFO overflow halt");

        $display("%0d frames, %0d checks, %0d errors", frames_seen, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #((NUM_TESTS * 200 + 5) * CLK_PERIOD);
        $display("watchdog expired with frames still outstanding");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hdl/dataframe_pkg.sv
hdl/fifo_port_if.sv
hdl/sync_fifo.sv
hdl/header_footer_gen.sv
hdl/frame_merger.sv
hdl/daq_readout_top.sv
tb/tb_daq_readout.sv

/* Bender.yml */
package:
  name: daq_readout

sources:
  - hdl/dataframe_pkg.sv
  - hdl/fifo_port_if.sv
  - hdl/sync_fifo.sv
  - hdl/header_footer_gen.sv
  - hdl/frame_merger.sv
  - hdl/daq_readout_top.sv
  - target: test
    files:
      - tb/tb_daq_readout.sv
